/* src/host_cfg_pkg.sv */
// Send engine sizes, register offsets and limits
package host_cfg_pkg;

	// Applications
	localparam int num_apps = 4;
	localparam int app_w = 2;

	// Pages and beats
	localparam int page_beats = 64;
	localparam int beat_bytes = 64;
	localparam int page_ld = $clog2(page_beats);
	localparam int byte_ld = $clog2(beat_bytes);
	localparam int idx_w = 15;
	// Low address bits covered by one application's send region
	localparam int region_ld = idx_w + byte_ld;

	// Bus widths
	localparam int addr_w = 49;
	localparam int data_w = 64;
	localparam int reg_addr_w = 32;
	localparam int cred_w = 16;

	// Throttling and queue depths
	localparam int send_limit_ld = 4;
	localparam int send_limit = 1 << send_limit_ld;
	localparam int cmd_depth_ld = 5;
	localparam int burst_depth_ld = 1;

	// Register offsets
	localparam logic [reg_addr_w-1:0] reg_send_base = 'h00;
	localparam logic [reg_addr_w-1:0] reg_send_cmd = 'h08;

endpackage

/* src/host_msg_pkg.sv */
// Register request and response structs
// Send command and read burst structs
package host_msg_pkg;
	import host_cfg_pkg::*;

	// One register access, no back-pressure
	typedef struct packed {
		logic valid;
		logic write;
		logic [app_w-1:0] app;
		logic [reg_addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} reg_req_t;

	typedef struct packed {
		logic valid;
		logic [data_w-1:0] data;
	} reg_resp_t;

	// Length is in beats minus one
	typedef struct packed {
		logic [idx_w-1:0] len;
		logic last;
	} send_cmd_t;

	// Page-bounded read burst, length in beats minus one
	typedef struct packed {
		logic [app_w-1:0] app;
		logic [addr_w-1:0] addr;
		logic [page_ld-1:0] len;
		logic last;
	} burst_t;

endpackage

/* src/payload_fifo.sv */
// Synchronous FIFO for any packed payload type
module payload_fifo #(
	parameter type payload_t = logic,
	parameter int depth_ld = 1
) (
	input clk,
	input rst,

	input payload_t in,
	input in_valid,
	output logic in_ready,

	output payload_t out,
	output logic out_valid,
	input out_ready
);

localparam int depth = 1 << depth_ld;

payload_t mem [depth];
logic [depth_ld-1:0] wr_ptr;
logic [depth_ld-1:0] rd_ptr;
logic [depth_ld:0] count;

wire push = in_valid && in_ready;
wire pop = out_valid && out_ready;

assign in_ready = count != (depth_ld+1)'(depth);
assign out_valid = count != '0;
assign out = mem[rd_ptr];

always_ff @(posedge clk) begin
	if (push) mem[wr_ptr] <= in;
end

always_ff @(posedge clk) begin
	if (rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (push) wr_ptr <= wr_ptr + 1'b1;
		if (pop) rd_ptr <= rd_ptr + 1'b1;
		count <= count + (depth_ld+1)'(push) - (depth_ld+1)'(pop);
	end
end

endmodule

/* src/send_regs.sv */
// Per-application send registers
// Base address, command push and completed-command credits
module send_regs
	import host_cfg_pkg::*, host_msg_pkg::*;
(
	input clk,
	input rst,

	input reg_req_t reg_req,
	output reg_resp_t reg_resp,

	output send_cmd_t [num_apps-1:0] cmd,
	output logic [num_apps-1:0] cmd_valid,
	output logic [num_apps-1:0][addr_w-1:0] send_base,
	output logic [num_apps-1:0] stream_rst,
	input [num_apps-1:0] cmd_done
);

logic [cred_w-1:0] credits [num_apps];
logic [num_apps-1:0] use_creds;

wire reg_wr = reg_req.valid && reg_req.write;
wire reg_rd = reg_req.valid && !reg_req.write;

// Decode
always_comb begin
	for (int i = 0; i < num_apps; i++) begin
		cmd[i].len = reg_req.data[idx_w:1];
		cmd[i].last = reg_req.data[0];

		stream_rst[i] = reg_wr && (reg_req.app == app_w'(i)) && (reg_req.addr == reg_send_base);
		cmd_valid[i] = reg_wr && (reg_req.app == app_w'(i)) && (reg_req.addr == reg_send_cmd);
		use_creds[i] = reg_rd && (reg_req.app == app_w'(i)) && (reg_req.addr == reg_send_cmd);
	end
end

always_ff @(posedge clk) begin
	if (reg_wr && (reg_req.addr == reg_send_base)) begin
		send_base[reg_req.app] <= reg_req.data[addr_w-1:0];
	end
end

// Credits, read clears
always_ff @(posedge clk) begin
	for (int i = 0; i < num_apps; i++) begin
		credits[i] <= (use_creds[i] ? '0 : credits[i]) + cred_w'(cmd_done[i]);

		if (stream_rst[i]) credits[i] <= '0;

		if (rst) credits[i] <= '0;
	end
end

// Read response one cycle after the request
always_ff @(posedge clk) begin
	if (rst) begin
		reg_resp <= '0;
	end else begin
		reg_resp.valid <= reg_rd;
		reg_resp.data <= '0;
		if (reg_rd) begin
			case (reg_req.addr)
				reg_send_base: reg_resp.data <= data_w'(send_base[reg_req.app]);
				reg_send_cmd: reg_resp.data <= data_w'(credits[reg_req.app]);
				default: reg_resp.data <= '0;
			endcase
		end
	end
end

endmodule

/* src/page_segmenter.sv */
// Splits one application's send commands into page-bounded read bursts
// Outstanding-burst limit per application
module page_segmenter
	import host_cfg_pkg::*, host_msg_pkg::*;
#(
	parameter int app_id = 0
) (
	input clk,
	input rst,

	input send_cmd_t cmd,
	input cmd_valid,
	output logic cmd_ready,

	input [addr_w-1:0] send_base,
	input stream_rst,
	input done,

	output burst_t burst,
	output logic burst_valid,
	input burst_ready,

	output logic cmd_done
);

logic [idx_w-1:0] idx;
logic [idx_w-1:0] len_done;
logic [send_limit_ld:0] limit;

logic [idx_w-1:0] len_left;
logic [page_ld-1:0] page_len;
logic [page_ld-1:0] len;
logic fin;
logic fire;

// Both lengths are in beats minus one
assign len_left = cmd.len - len_done;
assign page_len = page_ld'(page_beats - 1) - idx[page_ld-1:0];
assign fin = len_left <= idx_w'(page_len);
assign len = fin ? len_left[page_ld-1:0] : page_len;

assign burst_valid = cmd_valid && (limit != '0);
assign fire = burst_valid && burst_ready;

assign burst.app = app_w'(app_id);
assign burst.addr = {send_base[addr_w-1:region_ld], idx, byte_ld'(0)};
assign burst.len = len;
assign burst.last = fin && cmd.last;

// Pop the command with its final burst
assign cmd_ready = fire && fin;
assign cmd_done = fire && fin;

always_ff @(posedge clk) begin
	if (fire) begin
		idx <= idx + idx_w'(len) + idx_w'(1);
		len_done <= fin ? '0 : (len_done + idx_w'(len) + idx_w'(1));
	end

	limit <= limit + (send_limit_ld+1)'(done) - (send_limit_ld+1)'(fire);

	if (stream_rst || rst) begin
		idx <= '0;
		len_done <= '0;
		limit <= (send_limit_ld+1)'(send_limit);
	end
end

endmodule

/* src/rr_arbiter.sv */
// Round-robin arbiter from per-application burst queues to the read-request port
module rr_arbiter
	import host_cfg_pkg::*, host_msg_pkg::*;
(
	input clk,
	input rst,

	input burst_t [num_apps-1:0] heads,
	input [num_apps-1:0] head_valid,
	output logic [num_apps-1:0] head_ready,

	output burst_t rd_req,
	output logic rd_req_valid,
	input rd_req_ready
);

logic [app_w-1:0] prio;
logic [app_w-1:0] pick;
logic [app_w-1:0] sel;
logic locked;
logic [app_w-1:0] lock_sel;

wire xfer = rd_req_valid && rd_req_ready;

// First valid app at or after the pointer
always_comb begin
	logic [app_w-1:0] idx;
	logic found;

	pick = prio;
	found = 1'b0;
	for (int i = 0; i < num_apps; i++) begin
		idx = prio + app_w'(i);
		if (!found && head_valid[idx]) begin
			pick = idx;
			found = 1'b1;
		end
	end
end

// A stalled grant stays put until it transfers
assign sel = locked ? lock_sel : pick;

assign rd_req = heads[sel];
assign rd_req_valid = |head_valid;

always_comb begin
	head_ready = '0;
	head_ready[sel] = xfer;
end

always_ff @(posedge clk) begin
	lock_sel <= sel;

	if (rst) begin
		prio <= '0;
		locked <= 1'b0;
	end else begin
		locked <= rd_req_valid && !rd_req_ready;
		if (xfer) prio <= sel + 1'b1;
	end
end

endmodule

/* src/host_send_engine.sv */
// Host send engine top level
// Register file, command and burst queues, segmenters, arbiter
module host_send_engine
	import host_cfg_pkg::*, host_msg_pkg::*;
(
	input clk,
	input rst,

	input reg_req_t reg_req,
	output reg_resp_t reg_resp,

	output burst_t rd_req,
	output logic rd_req_valid,
	input rd_req_ready,
	input [num_apps-1:0] rd_done
);

send_cmd_t [num_apps-1:0] push_cmd;
logic [num_apps-1:0] push_valid;
logic [num_apps-1:0][addr_w-1:0] send_base;
logic [num_apps-1:0] stream_rst;
logic [num_apps-1:0] cmd_done;

send_cmd_t [num_apps-1:0] q_cmd;
logic [num_apps-1:0] q_cmd_valid;
logic [num_apps-1:0] q_cmd_ready;

burst_t [num_apps-1:0] seg_burst;
logic [num_apps-1:0] seg_valid;
logic [num_apps-1:0] seg_ready;

burst_t [num_apps-1:0] heads;
logic [num_apps-1:0] head_valid;
logic [num_apps-1:0] head_ready;

send_regs regs (
	.clk(clk),
	.rst(rst),
	.reg_req(reg_req),
	.reg_resp(reg_resp),
	.cmd(push_cmd),
	.cmd_valid(push_valid),
	.send_base(send_base),
	.stream_rst(stream_rst),
	.cmd_done(cmd_done)
);

for (genvar i = 0; i < num_apps; i++) begin : app
	// Pushes into a full command queue are dropped
	payload_fifo #(
		.payload_t(send_cmd_t),
		.depth_ld(cmd_depth_ld)
	) cmd_fifo (
		.clk(clk),
		.rst(rst),
		.in(push_cmd[i]),
		.in_valid(push_valid[i]),
		.in_ready(),
		.out(q_cmd[i]),
		.out_valid(q_cmd_valid[i]),
		.out_ready(q_cmd_ready[i])
	);

	page_segmenter #(
		.app_id(i)
	) seg (
		.clk(clk),
		.rst(rst),
		.cmd(q_cmd[i]),
		.cmd_valid(q_cmd_valid[i]),
		.cmd_ready(q_cmd_ready[i]),
		.send_base(send_base[i]),
		.stream_rst(stream_rst[i]),
		.done(rd_done[i]),
		.burst(seg_burst[i]),
		.burst_valid(seg_valid[i]),
		.burst_ready(seg_ready[i]),
		.cmd_done(cmd_done[i])
	);

	payload_fifo #(
		.payload_t(burst_t),
		.depth_ld(burst_depth_ld)
	) burst_fifo (
		.clk(clk),
		.rst(rst),
		.in(seg_burst[i]),
		.in_valid(seg_valid[i]),
		.in_ready(seg_ready[i]),
		.out(heads[i]),
		.out_valid(head_valid[i]),
		.out_ready(head_ready[i])
	);
end

rr_arbiter arb (
	.clk(clk),
	.rst(rst),
	.heads(heads),
	.head_valid(head_valid),
	.head_ready(head_ready),
	.rd_req(rd_req),
	.rd_req_valid(rd_req_valid),
	.rd_req_ready(rd_req_ready)
);

endmodule

/* tb/tb_host_send_engine.sv */
// Testbench for the host send engine
// Reference burst model, round-robin and handshake checks
module tb_host_send_engine
	import host_cfg_pkg::*, host_msg_pkg::*;
;

localparam int max_cycles = 4000;

logic clk = 1'b0;
logic rst;
reg_req_t reg_req;
reg_resp_t reg_resp;
burst_t rd_req;
logic rd_req_valid;
logic rd_req_ready;
logic [num_apps-1:0] rd_done;

burst_t exp_q [num_apps][$];
int model_idx [num_apps];
int xfer_count [num_apps];
logic [app_w-1:0] rr_ptr;
logic check_rr;
logic prev_stall;
burst_t prev_req;
string cur_test;
int errors;
int tests;
int cycles;
logic [31:0] seed;

host_send_engine uut (
	.clk(clk),
	.rst(rst),
	.reg_req(reg_req),
	.reg_resp(reg_resp),
	.rd_req(rd_req),
	.rd_req_valid(rd_req_valid),
	.rd_req_ready(rd_req_ready),
	.rd_done(rd_done)
);

always #4 clk = ~clk;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic value_error(input string what, input logic [63:0] exp, input logic [63:0] act);
	$display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
	errors++;
endtask

task automatic other_error(input string msg);
	$display("[ERROR] %s: %s", cur_test, msg);
	errors++;
endtask

// Splits a command by the page rule into expected bursts
task automatic expect_cmd(input int app, input logic [addr_w-1:0] base, input int beats,
		input logic last);
	int left;
	int n;
	burst_t b;
	left = beats;
	while (left > 0) begin
		n = page_beats - (model_idx[app] % page_beats);
		if (left < n) n = left;
		b.app = app_w'(app);
		b.addr = (base & ~((addr_w'(1) << 21) - 1)) | addr_w'(model_idx[app] * beat_bytes);
		b.len = page_ld'(n - 1);
		b.last = last && (n == left);
		exp_q[app].push_back(b);
		model_idx[app] += n;
		left -= n;
	end
endtask

task automatic reg_write(input int app, input logic [reg_addr_w-1:0] addr,
		input logic [data_w-1:0] data);
	@(posedge clk);
	#1;
	reg_req = '{valid: 1'b1, write: 1'b1, app: app_w'(app), addr: addr, data: data};
	@(posedge clk);
	#1;
	reg_req = '0;
endtask

task automatic set_base(input int app, input logic [addr_w-1:0] base);
	reg_write(app, reg_send_base, data_w'(base));
	model_idx[app] = 0;
endtask

task automatic push_cmd(input int app, input logic [addr_w-1:0] base, input int beats,
		input logic last);
	reg_write(app, reg_send_cmd, data_w'({idx_w'(beats - 1), last}));
	expect_cmd(app, base, beats, last);
endtask

// Response must be valid exactly one cycle after the request
task automatic reg_read(input int app, input logic [reg_addr_w-1:0] addr,
		input logic [data_w-1:0] exp);
	@(posedge clk);
	#1;
	reg_req = '{valid: 1'b1, write: 1'b0, app: app_w'(app), addr: addr, data: '0};
	assert (!reg_resp.valid) else other_error("response valid before the read");
	@(posedge clk);
	#1;
	reg_req = '0;
	assert (reg_resp.valid) else other_error("no response one cycle after the read");
	assert (reg_resp.data == exp) else value_error("read data", exp, reg_resp.data);
	@(posedge clk);
	#1;
	assert (!reg_resp.valid) else other_error("response valid held too long");
endtask

task automatic wait_drained();
	while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
		@(posedge clk);
		#1;
	end
endtask

task automatic finish_test();
	tests++;
	$display("test %s done, errors so far %0d", cur_test, errors);
endtask

// Transfer monitor
always @(posedge clk) begin
	int a;
	int p;
	if (!rst) begin
		if (prev_stall) begin
			assert (rd_req_valid) else other_error("rd_req_valid fell before transfer");
			assert (rd_req == prev_req) else value_error("held payload", prev_req, rd_req);
		end
		if (rd_req_valid && rd_req_ready) begin
			a = rd_req.app;
			if (check_rr) begin
				p = rr_ptr;
				for (int i = 0; i < num_apps; i++) begin
					if (exp_q[(rr_ptr + i) % num_apps].size() == 0 && p == (rr_ptr + i) % num_apps)
						p = (p + 1) % num_apps;
				end
				assert (a == p) else value_error("granted app", p, a);
			end
			if (exp_q[a].size() == 0) begin
				other_error("burst seen with none expected");
			end else begin
				assert (rd_req == exp_q[a][0]) else value_error("burst", exp_q[a][0], rd_req);
				void'(exp_q[a].pop_front());
			end
			xfer_count[a]++;
			rr_ptr <= rd_req.app + 1'b1;
		end
	end
	prev_stall <= rd_req_valid && !rd_req_ready && !rst;
	prev_req <= rd_req;
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= max_cycles) begin
		$display("Run stopped at the cycle limit in test %s", cur_test);
		$display("Simulation FAILED");
		$finish;
	end
end

initial begin
	logic [addr_w-1:0] base2;
	rst = 1'b1;
	reg_req = '0;
	rd_req_ready = 1'b0;
	rd_done = '0;
	rr_ptr = '0;
	check_rr = 1'b0;
	prev_stall = 1'b0;
	errors = 0;
	tests = 0;
	cycles = 0;
	seed = 32'he467;
	cur_test = "reset";
	for (int i = 0; i < num_apps; i++) begin
		model_idx[i] = 0;
		xfer_count[i] = 0;
	end
	repeat (5) @(posedge clk);
	#1;
	rst = 1'b0;

	assert (!rd_req_valid && !reg_resp.valid) else other_error("outputs valid after reset");
	reg_read(0, reg_send_cmd, 0);
	finish_test();

	cur_test = "base_readback";
	set_base(1, 49'h1_5a5a_0123_4567);
	reg_read(1, reg_send_base, 64'h1_5a5a_0123_4567);
	finish_test();

	// Partial first page, cleared last flag, then a command crossing a page
	cur_test = "page_split";
	base2 = 49'h0_abcd_e000_0000;
	rd_req_ready = 1'b1;
	set_base(2, base2);
	push_cmd(2, base2, 10, 1'b1);
	push_cmd(2, base2, 100, 1'b0);
	push_cmd(2, base2, 70, 1'b1);
	wait_drained();
	finish_test();

	cur_test = "round_robin";
	rd_req_ready = 1'b0;
	for (int i = 0; i < 3; i++) begin
		set_base(i, addr_w'(i) << 30);
		push_cmd(i, addr_w'(i) << 30, 4 * page_beats, 1'b1);
	end
	repeat (10) @(posedge clk);
	#1;
	check_rr = 1'b1;
	rd_req_ready = 1'b1;
	wait_drained();
	check_rr = 1'b0;
	finish_test();

	cur_test = "back_pressure";
	for (int i = 0; i < 2; i++) begin
		set_base(i, addr_w'(i + 5) << 28);
		push_cmd(i, addr_w'(i + 5) << 28, 300, 1'b1);
		push_cmd(i, addr_w'(i + 5) << 28, 90, 1'b0);
	end
	while (exp_q[0].size() + exp_q[1].size() != 0) begin
		@(posedge clk);
		#1;
		seed = lcg_next(seed);
		rd_req_ready = seed[16];
	end
	rd_req_ready = 1'b1;
	finish_test();

	cur_test = "throttle_credits";
	set_base(3, 49'h0_0077_0000_0000);
	xfer_count[3] = 0;
	push_cmd(3, 49'h0_0077_0000_0000, 20 * page_beats, 1'b1);
	while (xfer_count[3] < 16) begin
		@(posedge clk);
		#1;
	end
	repeat (20) @(posedge clk);
	#1;
	assert (xfer_count[3] == 16) else value_error("bursts without rd_done", 16, xfer_count[3]);
	for (int i = 0; i < 4; i++) begin
		@(posedge clk);
		#1;
		rd_done[3] = 1'b1;
		@(posedge clk);
		#1;
		rd_done[3] = 1'b0;
	end
	wait_drained();
	reg_read(3, reg_send_cmd, 1);
	reg_read(3, reg_send_cmd, 0);
	finish_test();

	$display("tests %0d, errors %0d", tests, errors);
	if (errors == 0) begin
		$display("Simulation PASSED");
	end else begin
		$display("Simulation FAILED");
	end
	$finish;
end

endmodule

/* sim.f */
src/host_cfg_pkg.sv
src/host_msg_pkg.sv
src/payload_fifo.sv
src/send_regs.sv
src/page_segmenter.sv
src/rr_arbiter.sv
src/host_send_engine.sv
tb/tb_host_send_engine.sv

/* Makefile */
TOOL := verilator
FLAGS := --binary --timing
TOP := tb_host_send_engine
FILE_LIST := sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
